/* logic/ps2_pkg.sv */
// PS/2 wire-side types shared by the receiver, decoder and lookup
// Scan code set 2 only, so the extended flag is the single E0 prefix
`default_nettype none

package ps2_pkg;

    // One data byte from a PS/2 frame
    typedef logic [7:0] ps2_byte_t;

    // Extended flag above the raw code
    typedef logic [8:0] scan_code_t;

    // Complete key event out of the prefix decoder
    typedef struct packed {
        logic       strobe;    // One cycle per key event
        logic       released;  // Set after an F0 prefix
        scan_code_t code;      // Bit 8 is the E0 prefix
    } key_event_t;

endpackage

`default_nettype wire

/* logic/arcade_keys_pkg.sv */
// Control-side types for the arcade key mapping
// Bit order inside each group follows the core's joystick conventions
`default_nettype none

package arcade_keys_pkg;

    // Which held group an action writes
    typedef enum logic [3:0] {
        grp_none,
        grp_joy1,
        grp_joy2,
        grp_joy3,
        grp_coin,
        grp_start,
        grp_system,
        grp_gfx,
        grp_debug,
        grp_joy2_joy3_shared   // K key, joy2 bit 9 plus joy3 bit 2
    } target_group_t;

    // Bit position inside a group
    typedef logic [3:0] bit_index_t;

    typedef struct packed {
        logic          strobe;  // One cycle per action
        target_group_t group;
        bit_index_t    index;
        logic          level;   // 1 when pressed
    } key_action_t;

    // Every held control level, 45 bits
    typedef struct packed {
        logic [9:0] joy1;    // Buttons 6..1 then up down left right
        logic [9:0] joy2;
        logic [6:0] joy3;
        logic [3:0] coin;
        logic [3:0] start;
        logic [3:0] system;  // Service, reset, test, pause from msb
        logic [3:0] gfx;     // Layer enables
        logic [1:0] debug;   // Minus in bit 1, plus in bit 0
    } arcade_controls_t;

endpackage

`default_nettype wire

/* logic/ps2_frame_receiver.sv */
// Receive-only PS/2 device port, keyboard to host
// Lines are asynchronous, idle high; partial frames die after FRAME_TIMEOUT clocks
`timescale 1ns/1ns
`default_nettype none

module ps2_frame_receiver
    import ps2_pkg::*;
#(
    parameter int FILTER_LEN    = 8,     // Equal samples to accept a clock level
    parameter int FRAME_TIMEOUT = 4000   // Idle clocks before a partial frame drops
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      ps2_clk,
    input  logic      ps2_data,
    output ps2_byte_t rx_byte,
    output logic      rx_valid,
    output logic      frame_error
);

    localparam int FILT_W = $clog2(FILTER_LEN + 1);
    localparam int IDLE_W = $clog2(FRAME_TIMEOUT + 1);

    logic [1:0]        clk_sync;
    logic [1:0]        data_sync;
    logic [FILT_W-1:0] filt_cnt;
    logic              clk_filt;    // Debounced ps2_clk
    logic              clk_filt_d;
    logic              clk_fall;
    logic [9:0]        shift_reg;   // First ten bits, start bit ends in bit 0
    logic [10:0]       frame;
    logic              frame_ok;
    logic [3:0]        bit_cnt;
    logic [IDLE_W-1:0] idle_cnt;

    // Two-flop synchronizers, idle high
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // Glitch filter on the clock line only
    always_ff @(posedge clk) begin
        if (rst) begin
            filt_cnt   <= '0;
            clk_filt   <= 1'b1;
            clk_filt_d <= 1'b1;
        end else begin
            clk_filt_d <= clk_filt;
            if (clk_sync[1] == clk_filt) begin
                filt_cnt <= '0;                      // Level agrees, restart count
            end else if (filt_cnt == FILT_W'(FILTER_LEN - 1)) begin
                filt_cnt <= '0;
                clk_filt <= clk_sync[1];             // Stable long enough
            end else begin
                filt_cnt <= filt_cnt + 1'b1;
            end
        end
    end

    assign clk_fall = clk_filt_d & ~clk_filt;        // Device drives data before this
    assign frame    = {data_sync[1], shift_reg};     // Stop bit arrives last
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);   // Odd parity

    // Bit counter, idle timeout and result strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt     <= '0;
            idle_cnt    <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt     <= '0;
                    rx_valid    <= frame_ok;
                    frame_error <= ~frame_ok;        // Byte is dropped
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt != 4'd0) begin
                if (idle_cnt == IDLE_W'(FRAME_TIMEOUT - 1)) begin
                    bit_cnt  <= '0;                  // Resync on next start bit
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shift_reg <= {data_sync[1], shift_reg[9:1]};   // LSB first on the wire
        end
        if (clk_fall && bit_cnt == 4'd10) begin
            rx_byte <= frame[8:1];
        end
    end

endmodule

`default_nettype wire

/* logic/scan_code_decoder.sv */
// Set 2 prefix decoder, E0 marks extended and F0 marks break
// Pause/Break's E1 sequence is not recognised and yields junk events
`timescale 1ns/1ns
`default_nettype none

module scan_code_decoder
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  ps2_byte_t  rx_byte,
    input  logic       rx_valid,
    output key_event_t key_event
);

    typedef enum logic [1:0] {
        st_idle,
        st_extended,
        st_released,
        st_extended_released
    } dec_state_t;

    dec_state_t state;
    logic       ext_flag;
    logic       rel_flag;
    logic       is_prefix;

    assign ext_flag  = (state == st_extended) || (state == st_extended_released);
    assign rel_flag  = (state == st_released) || (state == st_extended_released);
    assign is_prefix = (rx_byte == 8'he0) || (rx_byte == 8'hf0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            key_event <= '0;
        end else begin
            key_event.strobe <= rx_valid & ~is_prefix;
            if (rx_valid) begin
                case (rx_byte)
                    8'he0: state <= rel_flag ? st_extended_released : st_extended;
                    8'hf0: state <= ext_flag ? st_extended_released : st_released;
                    default: begin
                        state              <= st_idle;   // Code ends the sequence
                        key_event.released <= rel_flag;
                        key_event.code     <= {ext_flag, rx_byte};
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/key_map_lookup.sv */
// Fixed scan code set 2 layout for three joysticks and cabinet keys
// Codes not in the table give group none and are ignored downstream
`timescale 1ns/1ns
`default_nettype none

module key_map_lookup
    import ps2_pkg::*;
    import arcade_keys_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  key_event_t  key_event,
    output key_action_t key_action
);

    typedef struct packed {
        target_group_t group;
        bit_index_t    index;
    } key_target_t;

    key_target_t target;

    always_comb begin
        case (key_event.code)
            // Player 1
            9'h0_22: target = '{grp_joy1, 4'd9};    // Button 6 on X
            9'h0_1a: target = '{grp_joy1, 4'd8};    // Button 5 on Z
            9'h0_12: target = '{grp_joy1, 4'd7};    // Left shift
            9'h0_29: target = '{grp_joy1, 4'd6};    // Space
            9'h0_11: target = '{grp_joy1, 4'd5};    // Left alt
            9'h0_14: target = '{grp_joy1, 4'd4};    // Left ctrl
            9'h1_75: target = '{grp_joy1, 4'd3};    // Arrow up
            9'h1_72: target = '{grp_joy1, 4'd2};    // Arrow down
            9'h1_6b: target = '{grp_joy1, 4'd1};    // Arrow left
            9'h1_74: target = '{grp_joy1, 4'd0};    // Arrow right
            // Player 2
            9'h0_24: target = '{grp_joy2, 4'd8};    // E
            9'h0_1d: target = '{grp_joy2, 4'd7};    // W
            9'h0_15: target = '{grp_joy2, 4'd6};    // Q
            9'h0_1b: target = '{grp_joy2, 4'd5};    // S
            9'h0_1c: target = '{grp_joy2, 4'd4};    // A
            9'h0_2d: target = '{grp_joy2, 4'd3};    // Up on R
            9'h0_2b: target = '{grp_joy2, 4'd2};    // Down on F
            9'h0_23: target = '{grp_joy2, 4'd1};    // Left on D
            9'h0_34: target = '{grp_joy2, 4'd0};    // Right on G
            9'h0_42: target = '{grp_joy2_joy3_shared, 4'd0};   // K drives both sticks
            // Player 3
            9'h0_5a: target = '{grp_joy3, 4'd6};    // Enter
            9'h0_59: target = '{grp_joy3, 4'd5};    // Right shift
            9'h1_14: target = '{grp_joy3, 4'd4};    // Right ctrl
            9'h0_43: target = '{grp_joy3, 4'd3};    // Up on I
            9'h0_3b: target = '{grp_joy3, 4'd1};    // Left on J
            9'h0_4b: target = '{grp_joy3, 4'd0};    // Right on L
            // Coins on 5 to 8
            9'h0_2e: target = '{grp_coin, 4'd0};
            9'h0_36: target = '{grp_coin, 4'd1};
            9'h0_3d: target = '{grp_coin, 4'd2};
            9'h0_3e: target = '{grp_coin, 4'd3};
            // Starts on 1 to 4
            9'h0_16: target = '{grp_start, 4'd0};
            9'h0_1e: target = '{grp_start, 4'd1};
            9'h0_26: target = '{grp_start, 4'd2};
            9'h0_25: target = '{grp_start, 4'd3};
            // Cabinet switches
            9'h0_4d: target = '{grp_system, 4'd0};  // Pause on P
            9'h0_06: target = '{grp_system, 4'd1};  // Test on F2
            9'h0_04: target = '{grp_system, 4'd2};  // Reset on F3
            9'h0_46: target = '{grp_system, 4'd3};  // Service on 9
            // Layer enables
            9'h0_83: target = '{grp_gfx, 4'd0};     // F7 char layer
            9'h0_0a: target = '{grp_gfx, 4'd1};     // F8 scroll 1
            9'h0_01: target = '{grp_gfx, 4'd2};     // F9 scroll 2
            9'h0_09: target = '{grp_gfx, 4'd3};     // F10 objects
            // Debug stepping
            9'h0_5b: target = '{grp_debug, 4'd0};   // Plus on ]
            9'h0_4a: target = '{grp_debug, 4'd1};   // Minus on /
            default: target = '{grp_none, 4'd0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            key_action <= '0;
        end else begin
            key_action.strobe <= key_event.strobe;
            key_action.group  <= target.group;
            key_action.index  <= target.index;
            key_action.level  <= ~key_event.released;  // Make code presses
        end
    end

endmodule

`default_nettype wire

/* logic/control_state.sv */
// Held control levels, written one bit per key action
// No repeat handling, a lost break code leaves its bit set until the next make/break
`timescale 1ns/1ns
`default_nettype none

module control_state
    import arcade_keys_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  key_action_t      key_action,
    output arcade_controls_t controls,
    output logic             shift
);

    arcade_controls_t next_controls;

    always_comb begin
        next_controls = controls;
        if (key_action.strobe) begin
            case (key_action.group)
                grp_joy1:   next_controls.joy1[key_action.index]        = key_action.level;
                grp_joy2:   next_controls.joy2[key_action.index]        = key_action.level;
                grp_joy3:   next_controls.joy3[key_action.index[2:0]]   = key_action.level;
                grp_coin:   next_controls.coin[key_action.index[1:0]]   = key_action.level;
                grp_start:  next_controls.start[key_action.index[1:0]]  = key_action.level;
                grp_system: next_controls.system[key_action.index[1:0]] = key_action.level;
                grp_gfx:    next_controls.gfx[key_action.index[1:0]]    = key_action.level;
                grp_debug:  next_controls.debug[key_action.index[0]]    = key_action.level;
                grp_joy2_joy3_shared: begin
                    next_controls.joy2[9] = key_action.level;   // P2 button 6
                    next_controls.joy3[2] = key_action.level;   // P3 down
                end
                default: ;                                      // Unmapped key
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            controls <= '0;
            shift    <= 1'b0;
        end else begin
            controls <= next_controls;
            // Either shift key, same cycle as the levels
            shift    <= next_controls.joy1[7] | next_controls.joy3[5];
        end
    end

endmodule

`default_nettype wire

/* logic/ps2_arcade_keys.sv */
// PS/2 keyboard to arcade controls, receive path only
// Controls follow the last byte of a scan code by 3 clocks after rx_valid
`timescale 1ns/1ns
`default_nettype none

module ps2_arcade_keys
    import ps2_pkg::*;
    import arcade_keys_pkg::*;
#(
    parameter int FILTER_LEN    = 8,
    parameter int FRAME_TIMEOUT = 4000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ps2_clk,
    input  logic             ps2_data,
    output arcade_controls_t controls,
    output logic             shift,
    output logic             frame_error
);

    ps2_byte_t   rx_byte;
    logic        rx_valid;
    key_event_t  key_event;
    key_action_t key_action;

    ps2_frame_receiver #(
        .FILTER_LEN    (FILTER_LEN),
        .FRAME_TIMEOUT (FRAME_TIMEOUT)
    ) u_ps2_frame_receiver (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_error (frame_error)
    );

    scan_code_decoder u_scan_code_decoder (
        .clk       (clk),
        .rst       (rst),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .key_event (key_event)
    );

    key_map_lookup u_key_map_lookup (
        .clk        (clk),
        .rst        (rst),
        .key_event  (key_event),
        .key_action (key_action)
    );

    control_state u_control_state (
        .clk        (clk),
        .rst        (rst),
        .key_action (key_action),
        .controls   (controls),
        .shift      (shift)
    );

endmodule

`default_nettype wire

/* verification/ps2_keyboard_model.svh */
// Keyboard side of a PS/2 link, device-to-host frames only
// Included inside a module that owns clk, ps2_clk and ps2_data; lines change on falling clk
`ifndef PS2_KEYBOARD_MODEL_SVH
`define PS2_KEYBOARD_MODEL_SVH

localparam int HALF_PERIOD = 40;   // clk cycles per PS/2 half period
localparam int FRAME_GAP   = 40;   // Idle line between frames

// One 11-bit frame, start bit first, odd parity unless forced bad
task automatic send_frame(input ps2_byte_t data, input logic bad_parity);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};   // Stop, parity, data, start
    for (i = 0; i < 11; i++) begin
        @(negedge clk);
        ps2_data = bits[i];                    // Data settles while clock is high
        repeat (HALF_PERIOD) @(negedge clk);
        ps2_clk = 1'b0;                        // Host samples on this edge
        repeat (HALF_PERIOD) @(negedge clk);
        ps2_clk = 1'b1;
    end
    repeat (FRAME_GAP) @(negedge clk);
endtask

// Whole set 2 scan code with its E0 and F0 prefixes
task automatic send_key(input scan_code_t code, input logic is_break);
    if (code[8]) begin
        send_frame(8'he0, 1'b0);               // Extended prefix goes first
    end
    if (is_break) begin
        send_frame(8'hf0, 1'b0);               // Break prefix
    end
    send_frame(code[7:0], 1'b0);
endtask

`endif

/* verification/ps2_arcade_keys_tb.sv */
// Drives whole scan codes at the PS/2 pins and checks the held control levels
// Each table row holds the cumulative expected state after its key
`timescale 1ns/1ns
`default_nettype none

module ps2_arcade_keys_tb
    import ps2_pkg::*;
    import arcade_keys_pkg::*;
;

    localparam int CLK_PERIOD    = 8;
    localparam int SETTLE_CYCLES = 200;   // After the last frame of a key

    typedef struct {
        scan_code_t       code;
        logic             is_break;
        logic             bad_parity;     // Send one corrupt frame instead of the key
        arcade_controls_t controls;
        logic             shift;
        int               frame_errors;   // Running total
    } step_t;

    logic             clk;
    logic             rst;
    logic             ps2_clk;
    logic             ps2_data;
    arcade_controls_t controls;
    logic             shift;
    logic             frame_error;

    step_t            steps[$];
    arcade_controls_t exp_ctl;
    logic             exp_shift;
    int               exp_fe;
    int               fe_count;
    int               errors;
    int               checks;
    logic             table_ready;
    longint           timeout_ns;

    `include "ps2_keyboard_model.svh"

    ps2_arcade_keys #(
        .FILTER_LEN    (8),
        .FRAME_TIMEOUT (4000)
    ) u_ps2_arcade_keys (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .controls    (controls),
        .shift       (shift),
        .frame_error (frame_error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Frame error pulses seen since reset
    always @(posedge clk) begin
        if (rst) begin
            fe_count <= 0;
        end else if (frame_error) begin
            fe_count <= fe_count + 1;
        end
    end

    // Snapshot of the running expectation
    function automatic void add_step(input scan_code_t code, input logic is_break,
                                     input logic bad_parity);
        step_t s;
        s.code         = code;
        s.is_break     = is_break;
        s.bad_parity   = bad_parity;
        s.controls     = exp_ctl;
        s.shift        = exp_shift;
        s.frame_errors = exp_fe;
        steps.push_back(s);
    endfunction

    task automatic build_table();
        exp_ctl   = '0;
        exp_shift = 1'b0;
        exp_fe    = 0;
        exp_ctl.joy1[9] = 1'b1;
        add_step(9'h022, 1'b0, 1'b0);     // X make
        exp_ctl.joy1[9] = 1'b0;
        add_step(9'h022, 1'b1, 1'b0);     // X break
        exp_ctl.coin[0] = 1'b1;
        add_step(9'h02e, 1'b0, 1'b0);     // Coin 1 on 5
        exp_ctl.coin[0] = 1'b0;
        add_step(9'h02e, 1'b1, 1'b0);
        exp_ctl.start[2] = 1'b1;
        add_step(9'h026, 1'b0, 1'b0);     // Start 3 on 3
        exp_ctl.start[2] = 1'b0;
        add_step(9'h026, 1'b1, 1'b0);
        exp_ctl.system[1] = 1'b1;
        add_step(9'h006, 1'b0, 1'b0);     // Test on F2
        exp_ctl.system[1] = 1'b0;
        add_step(9'h006, 1'b1, 1'b0);
        exp_ctl.gfx[2] = 1'b1;
        add_step(9'h001, 1'b0, 1'b0);     // F9 layer
        exp_ctl.gfx[2] = 1'b0;
        add_step(9'h001, 1'b1, 1'b0);
        exp_ctl.debug[1] = 1'b1;
        add_step(9'h04a, 1'b0, 1'b0);     // Debug minus on /
        exp_ctl.debug[1] = 1'b0;
        add_step(9'h04a, 1'b1, 1'b0);
        exp_ctl.joy1[4] = 1'b1;
        add_step(9'h014, 1'b0, 1'b0);     // Left ctrl
        exp_ctl.joy3[4] = 1'b1;
        add_step(9'h114, 1'b0, 1'b0);     // Right ctrl, same byte with E0
        exp_ctl.joy1[4] = 1'b0;
        add_step(9'h014, 1'b1, 1'b0);
        exp_ctl.joy3[4] = 1'b0;
        add_step(9'h114, 1'b1, 1'b0);
        add_step(9'h075, 1'b0, 1'b0);     // Keypad 8 is not mapped
        exp_ctl.joy1[3] = 1'b1;
        add_step(9'h175, 1'b0, 1'b0);     // Arrow up
        exp_ctl.joy1[3] = 1'b0;
        add_step(9'h175, 1'b1, 1'b0);
        exp_ctl.joy2[9] = 1'b1;
        exp_ctl.joy3[2] = 1'b1;
        add_step(9'h042, 1'b0, 1'b0);     // K hits both sticks
        exp_ctl.joy2[9] = 1'b0;
        exp_ctl.joy3[2] = 1'b0;
        add_step(9'h042, 1'b1, 1'b0);
        exp_ctl.joy1[7] = 1'b1;
        exp_shift       = 1'b1;
        add_step(9'h012, 1'b0, 1'b0);     // Left shift
        exp_ctl.joy3[5] = 1'b1;
        add_step(9'h059, 1'b0, 1'b0);     // Both shifts held
        exp_ctl.joy1[7] = 1'b0;
        add_step(9'h012, 1'b1, 1'b0);     // Right shift alone
        exp_ctl.joy3[5] = 1'b0;
        exp_shift       = 1'b0;
        add_step(9'h059, 1'b1, 1'b0);
        exp_fe = 1;
        add_step(9'h02e, 1'b0, 1'b1);     // Corrupt coin frame is dropped
        add_step(9'h00d, 1'b0, 1'b0);     // Tab, unmapped
    endtask

    task automatic check_controls(input arcade_controls_t exp, input arcade_controls_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t ns: controls expected %h, got %h", $time, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // Watchdog sized from the table, three frames per row at most
    initial begin
        wait (table_ready);
        timeout_ns = longint'(steps.size()) * (3 * 22 * HALF_PERIOD + 400) * CLK_PERIOD
                     + 20000;
        #(timeout_ns);
        $display("Timeout: run did not finish within %0d ns", timeout_ns);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        ps2_clk     = 1'b1;   // Open-drain lines idle high
        ps2_data    = 1'b1;
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (3) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        check_controls('0, controls);   // Clean state out of reset
        check_level("shift", 1'b0, shift);
        check_count("frame_error count", 0, fe_count);

        foreach (steps[i]) begin
            if (steps[i].bad_parity) begin
                send_frame(steps[i].code[7:0], 1'b1);
            end else begin
                send_key(steps[i].code, steps[i].is_break);
            end
            repeat (SETTLE_CYCLES) @(negedge clk);
            check_controls(steps[i].controls, controls);
            check_level("shift", steps[i].shift, shift);
            check_count("frame_error count", steps[i].frame_errors, fe_count);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ps2_arcade_keys.f */
logic/ps2_pkg.sv
logic/arcade_keys_pkg.sv
logic/ps2_frame_receiver.sv
logic/scan_code_decoder.sv
logic/key_map_lookup.sv
logic/control_state.sv
logic/ps2_arcade_keys.sv
+incdir+verification
verification/ps2_arcade_keys_tb.sv
